// ==== source/vgpr_pkg.sv ====
`default_nettype none

// Geometry of the vector register file and of one write-back request
package vgpr_pkg;

  // SIMD lanes in one vector register
  localparam int lane_count = 4;

  // Bits held by one lane of one register
  localparam int dword_width = 32;

  // Number of vector registers in the bank
  localparam int reg_count = 64;
  localparam int addr_width = $clog2(reg_count);

  // One write may cover this many consecutive registers, one enable bit each
  localparam int beat_count = 4;

  // One register across all lanes
  localparam int reg_width = lane_count * dword_width;

  // Chunk k of a write sits at k*reg_width, lane j of that chunk at j*dword_width
  localparam int wr_data_width = beat_count * reg_width;

endpackage

`default_nettype wire

// ==== source/wb_port_pkg.sv ====
`default_nettype none

// Write-back sources and the one-hot select that picks between them
package wb_port_pkg;

  localparam int port_count = 4;

  // One select bit per source
  localparam int select_width = port_count;

  // The value is both the port number and the bit position in the select
  typedef enum logic [1:0] {
    src_valu      = 2'd0,
    src_salu_move = 2'd1,
    src_lsu       = 2'd2,
    src_export    = 2'd3
  } wb_source_e;

endpackage

`default_nettype wire

// ==== source/wb_port_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_port_arbiter
  import wb_port_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [select_width-1:0] wr_request,
  output logic [select_width-1:0] wr_port_select
);

  localparam int ptr_width = $clog2(port_count);

  logic [ptr_width-1:0] rr_ptr;       // First port to look at this cycle
  logic [ptr_width-1:0] grant_idx;
  logic                 grant_found;

  // Scan upward from the pointer and wrap, the first requester wins
  always_comb
  begin
    wr_port_select = '0;
    grant_idx = rr_ptr;
    grant_found = 1'b0;
    for (int i = 0; i < port_count; i++)
    begin
      if (!grant_found && wr_request[(int'(rr_ptr) + i) % port_count])
      begin
        grant_found = 1'b1;
        grant_idx = ptr_width'((int'(rr_ptr) + i) % port_count);
      end
    end
    if (grant_found)
      wr_port_select[grant_idx] = 1'b1;
  end

  // The winner drops to lowest priority for the next cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rr_ptr <= '0;
    else if (grant_found)
    begin
      if (grant_idx == ptr_width'(port_count - 1))
        rr_ptr <= '0;
      else
        rr_ptr <= grant_idx + 1'b1;
    end
  end

  // At most one source owns the write port in any cycle
  a_select_onehot0 : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(wr_port_select)
  ) else $error("write port select is not one-hot");

  // A grant never goes to a port that is not asking
  a_grant_requested : assert property (
    @(posedge clk) disable iff (!rst_n)
    (wr_port_select & ~wr_request) == '0
  ) else $error("write port granted without a request");

endmodule

`default_nettype wire

// ==== source/wr_port_mux_4to1.sv ====
`timescale 1ns/1ns
`default_nettype none

module wr_port_mux_4to1
  import vgpr_pkg::*;
  import wb_port_pkg::*;
(
  input  logic                     clk,
  input  logic [select_width-1:0]  wr_port_select,
  input  logic [beat_count-1:0]    port0_wr_en,
  input  logic [lane_count-1:0]    port0_wr_mask,
  input  logic [addr_width-1:0]    port0_wr_addr,
  input  logic [wr_data_width-1:0] port0_wr_data,
  input  logic [beat_count-1:0]    port1_wr_en,
  input  logic [lane_count-1:0]    port1_wr_mask,
  input  logic [addr_width-1:0]    port1_wr_addr,
  input  logic [wr_data_width-1:0] port1_wr_data,
  input  logic [beat_count-1:0]    port2_wr_en,
  input  logic [lane_count-1:0]    port2_wr_mask,
  input  logic [addr_width-1:0]    port2_wr_addr,
  input  logic [wr_data_width-1:0] port2_wr_data,
  input  logic [beat_count-1:0]    port3_wr_en,
  input  logic [lane_count-1:0]    port3_wr_mask,
  input  logic [addr_width-1:0]    port3_wr_addr,
  input  logic [wr_data_width-1:0] port3_wr_data,
  output logic [beat_count-1:0]    muxed_wr_en,
  output logic [lane_count-1:0]    muxed_wr_mask,
  output logic [addr_width-1:0]    muxed_wr_addr,
  output logic [wr_data_width-1:0] muxed_wr_data
);

  always_comb
  begin
    unique case (wr_port_select)
      select_width'(1 << src_valu):
      begin
        muxed_wr_en   = port0_wr_en;
        muxed_wr_mask = port0_wr_mask;
        muxed_wr_addr = port0_wr_addr;
        muxed_wr_data = port0_wr_data;
      end
      select_width'(1 << src_salu_move):
      begin
        muxed_wr_en   = port1_wr_en;
        muxed_wr_mask = port1_wr_mask;
        muxed_wr_addr = port1_wr_addr;
        muxed_wr_data = port1_wr_data;
      end
      select_width'(1 << src_lsu):
      begin
        muxed_wr_en   = port2_wr_en;
        muxed_wr_mask = port2_wr_mask;
        muxed_wr_addr = port2_wr_addr;
        muxed_wr_data = port2_wr_data;
      end
      select_width'(1 << src_export):
      begin
        muxed_wr_en   = port3_wr_en;
        muxed_wr_mask = port3_wr_mask;
        muxed_wr_addr = port3_wr_addr;
        muxed_wr_data = port3_wr_data;
      end
      default:
      begin
        // Idle, or a broken select. Enable and mask low make address and data irrelevant
        muxed_wr_en   = '0;
        muxed_wr_mask = '0;
        muxed_wr_addr = 'x;
        muxed_wr_data = 'x;
      end
    endcase
  end

  // Two sources selected at once would silently drop one of the writes
  a_select_single : assert property (
    @(posedge clk) $onehot0(wr_port_select)
  ) else $error("more than one write port selected");

endmodule

`default_nettype wire

// ==== source/vgpr_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module vgpr_bank
  import vgpr_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [beat_count-1:0]    wr_en,
  input  logic [lane_count-1:0]    wr_mask,
  input  logic [addr_width-1:0]    wr_addr,
  input  logic [wr_data_width-1:0] wr_data,
  input  logic [addr_width-1:0]    rd_addr,
  output logic [reg_width-1:0]     rd_data
);

  // Each register is lane_count dwords, lane 0 in the low bits
  logic [lane_count-1:0][dword_width-1:0] regs [reg_count];

  logic [addr_width-1:0] beat_addr [beat_count];

  // Register hit by each enable bit, wrapping past the last register
  always_comb
  begin
    for (int k = 0; k < beat_count; k++)
      beat_addr[k] = wr_addr + addr_width'(k);
  end

  always_ff @(posedge clk)
  begin
    for (int k = 0; k < beat_count; k++)
    begin
      if (wr_en[k])
      begin
        for (int j = 0; j < lane_count; j++)
        begin
          if (wr_mask[j])   // Lanes with a clear mask bit keep their contents
            regs[beat_addr[k]][j] <= wr_data[k*reg_width + j*dword_width +: dword_width];
        end
      end
    end
  end

  // Sampled in the same edge as the write, so a collision returns the old value
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      rd_data <= '0;
    else
      rd_data <= regs[rd_addr];
  end

  // The mux drives an unknown address when idle. It must never pair with an enable
  a_wr_addr_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    (|wr_en) |-> !$isunknown(wr_addr)
  ) else $error("register write with unknown address");

endmodule

`default_nettype wire

// ==== source/vgpr_writeback.sv ====
`timescale 1ns/1ns
`default_nettype none

module vgpr_writeback
  import vgpr_pkg::*;
  import wb_port_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [beat_count-1:0]    port0_wr_en,
  input  logic [lane_count-1:0]    port0_wr_mask,
  input  logic [addr_width-1:0]    port0_wr_addr,
  input  logic [wr_data_width-1:0] port0_wr_data,
  input  logic [beat_count-1:0]    port1_wr_en,
  input  logic [lane_count-1:0]    port1_wr_mask,
  input  logic [addr_width-1:0]    port1_wr_addr,
  input  logic [wr_data_width-1:0] port1_wr_data,
  input  logic [beat_count-1:0]    port2_wr_en,
  input  logic [lane_count-1:0]    port2_wr_mask,
  input  logic [addr_width-1:0]    port2_wr_addr,
  input  logic [wr_data_width-1:0] port2_wr_data,
  input  logic [beat_count-1:0]    port3_wr_en,
  input  logic [lane_count-1:0]    port3_wr_mask,
  input  logic [addr_width-1:0]    port3_wr_addr,
  input  logic [wr_data_width-1:0] port3_wr_data,
  output logic                     port0_wr_grant,
  output logic                     port1_wr_grant,
  output logic                     port2_wr_grant,
  output logic                     port3_wr_grant,
  input  logic [addr_width-1:0]    rd_addr,
  output logic [reg_width-1:0]     rd_data
);

  logic [select_width-1:0]  wr_request;
  logic [select_width-1:0]  wr_port_select;
  logic [beat_count-1:0]    muxed_wr_en;
  logic [lane_count-1:0]    muxed_wr_mask;
  logic [addr_width-1:0]    muxed_wr_addr;
  logic [wr_data_width-1:0] muxed_wr_data;

  // Any enable bit counts as a request
  assign wr_request[src_valu]      = |port0_wr_en;
  assign wr_request[src_salu_move] = |port1_wr_en;
  assign wr_request[src_lsu]       = |port2_wr_en;
  assign wr_request[src_export]    = |port3_wr_en;

  // The grant tells a source its write lands at the coming edge
  assign port0_wr_grant = wr_port_select[src_valu];
  assign port1_wr_grant = wr_port_select[src_salu_move];
  assign port2_wr_grant = wr_port_select[src_lsu];
  assign port3_wr_grant = wr_port_select[src_export];

  wb_port_arbiter u_arbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_request     (wr_request),
    .wr_port_select (wr_port_select)
  );

  wr_port_mux_4to1 u_port_mux (
    .clk            (clk),
    .wr_port_select (wr_port_select),
    .port0_wr_en    (port0_wr_en),
    .port0_wr_mask  (port0_wr_mask),
    .port0_wr_addr  (port0_wr_addr),
    .port0_wr_data  (port0_wr_data),
    .port1_wr_en    (port1_wr_en),
    .port1_wr_mask  (port1_wr_mask),
    .port1_wr_addr  (port1_wr_addr),
    .port1_wr_data  (port1_wr_data),
    .port2_wr_en    (port2_wr_en),
    .port2_wr_mask  (port2_wr_mask),
    .port2_wr_addr  (port2_wr_addr),
    .port2_wr_data  (port2_wr_data),
    .port3_wr_en    (port3_wr_en),
    .port3_wr_mask  (port3_wr_mask),
    .port3_wr_addr  (port3_wr_addr),
    .port3_wr_data  (port3_wr_data),
    .muxed_wr_en    (muxed_wr_en),
    .muxed_wr_mask  (muxed_wr_mask),
    .muxed_wr_addr  (muxed_wr_addr),
    .muxed_wr_data  (muxed_wr_data)
  );

  vgpr_bank u_bank (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (muxed_wr_en),
    .wr_mask (muxed_wr_mask),
    .wr_addr (muxed_wr_addr),
    .wr_data (muxed_wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== bench/vgpr_writeback_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module vgpr_writeback_tb
  import vgpr_pkg::*;
  import wb_port_pkg::*;
();

  localparam int clk_period = 40;
  localparam int reset_cycles = 5;
  localparam int mask_writes = 32;
  localparam int multi_writes = 32;
  localparam int contention_rounds = 24;
  localparam int rdw_writes = 8;

  // Worst case cycles of each test, summed
  localparam int budget_cycles = (2 * reset_cycles + 4)
                               + (2 * reg_count + 4)
                               + (mask_writes + reg_count + 4)
                               + (multi_writes + reg_count + 4)
                               + (contention_rounds * (port_count + 1) + reg_count + 8)
                               + (3 * rdw_writes + 4);
  localparam int margin_ns = 20 * clk_period;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic [beat_count-1:0]    drv_en   [port_count];
  logic [lane_count-1:0]    drv_mask [port_count];
  logic [addr_width-1:0]    drv_addr [port_count];
  logic [wr_data_width-1:0] drv_data [port_count];
  logic [select_width-1:0]  grant_vec;
  logic [addr_width-1:0]    rd_addr;
  logic [reg_width-1:0]     rd_data;
  logic                     rd_req;       // rd_addr is a real read in this cycle
  logic                     count_check;  // Compare applied writes with issued requests

  // Reference model state
  logic [reg_width-1:0] shadow [reg_count];
  logic [reg_width-1:0] rd_expect;
  logic                 rd_pending = 1'b0;
  logic                 read_seen = 1'b0;
  int                   model_ptr = 0;

  int seed = 32'h102c_b712;
  int error_count = 0;
  int check_count = 0;
  int requests_issued = 0;
  int applied_writes = 0;

  vgpr_writeback dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .port0_wr_en    (drv_en[0]),
    .port0_wr_mask  (drv_mask[0]),
    .port0_wr_addr  (drv_addr[0]),
    .port0_wr_data  (drv_data[0]),
    .port1_wr_en    (drv_en[1]),
    .port1_wr_mask  (drv_mask[1]),
    .port1_wr_addr  (drv_addr[1]),
    .port1_wr_data  (drv_data[1]),
    .port2_wr_en    (drv_en[2]),
    .port2_wr_mask  (drv_mask[2]),
    .port2_wr_addr  (drv_addr[2]),
    .port2_wr_data  (drv_data[2]),
    .port3_wr_en    (drv_en[3]),
    .port3_wr_mask  (drv_mask[3]),
    .port3_wr_addr  (drv_addr[3]),
    .port3_wr_data  (drv_data[3]),
    .port0_wr_grant (grant_vec[0]),
    .port1_wr_grant (grant_vec[1]),
    .port2_wr_grant (grant_vec[2]),
    .port3_wr_grant (grant_vec[3]),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data)
  );

  always #(clk_period / 2) clk = ~clk;

  // Masked write of up to beat_count registers, the address wraps at reg_count
  function automatic void apply_write(input logic [beat_count-1:0] en,
                                      input logic [lane_count-1:0] mask,
                                      input logic [addr_width-1:0] addr,
                                      input logic [wr_data_width-1:0] data);
    int r;
    for (int k = 0; k < beat_count; k++)
    begin
      r = (int'(addr) + k) % reg_count;
      for (int j = 0; j < lane_count; j++)
      begin
        if (en[k] && mask[j])
          shadow[r][j*dword_width +: dword_width] = data[k*reg_width + j*dword_width +: dword_width];
      end
    end
  endfunction

  // First requester at or after the pointer wins
  function automatic logic [select_width-1:0] rr_grant(input logic [select_width-1:0] req,
                                                       input int ptr);
    logic [select_width-1:0] g;
    int idx;
    g = '0;
    for (int i = 0; i < port_count; i++)
    begin
      idx = (ptr + i) % port_count;
      if (g == '0 && req[idx])
        g[idx] = 1'b1;
    end
    return g;
  endfunction

  task automatic check_value(input string name, input logic [reg_width-1:0] expected,
                             input logic [reg_width-1:0] actual);
    check_count++;
    assert (actual === expected)
    else
    begin
      error_count++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic next_random(output logic [31:0] value);
    value = $random(seed);
  endtask

  task automatic random_data(output logic [wr_data_width-1:0] data);
    logic [31:0] w;
    for (int i = 0; i < wr_data_width / 32; i++)
    begin
      next_random(w);
      data[i*32 +: 32] = w;
    end
  endtask

  // Holds the request until the port sees its grant, then releases it at the write edge
  task automatic send_write(input int p, input logic [beat_count-1:0] en,
                            input logic [lane_count-1:0] mask,
                            input logic [addr_width-1:0] addr,
                            input logic [wr_data_width-1:0] data);
    logic granted;
    drv_en[p] <= en;
    drv_mask[p] <= mask;
    drv_addr[p] <= addr;
    drv_data[p] <= data;
    requests_issued++;
    granted = 1'b0;
    while (!granted)
    begin
      @(negedge clk);
      granted = grant_vec[p];
      @(posedge clk);
    end
    drv_en[p] <= '0;
  endtask

  task automatic read_all;
    for (int r = 0; r < reg_count; r++)
    begin
      rd_addr <= addr_width'(r);
      rd_req <= 1'b1;
      @(posedge clk);
    end
    rd_req <= 1'b0;
    @(posedge clk);   // Last read is compared in this cycle
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before)
      $display("%-22s passed", name);
    else
      $display("%-22s failed with %0d mismatches", name, error_count - errors_before);
  endtask

  task automatic check_reset;
    int errors_before;
    errors_before = error_count;
    repeat (reset_cycles - 1) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);   // Idle after reset, grants and rd_data stay low
    report_test("reset", errors_before);
  endtask

  // Register r goes through enable bit r % beat_count, so every chunk is exercised
  task automatic fill_bank;
    int errors_before;
    int k;
    logic [wr_data_width-1:0] data;
    errors_before = error_count;
    for (int r = 0; r < reg_count; r++)
    begin
      k = r % beat_count;
      random_data(data);
      send_write(r % port_count, beat_count'(1 << k), '1,
                 addr_width'((r - k + reg_count) % reg_count), data);
    end
    read_all();
    report_test("single source fill", errors_before);
  endtask

  task automatic write_masked_lanes;
    int errors_before;
    logic [31:0] w;
    logic [wr_data_width-1:0] data;
    errors_before = error_count;
    for (int i = 0; i < mask_writes; i++)
    begin
      next_random(w);
      random_data(data);
      send_write(int'(w[13:12]), beat_count'(1) << w[5:4], w[lane_count-1:0],
                 w[16 +: addr_width], data);
    end
    read_all();
    report_test("lane masking", errors_before);
  endtask

  task automatic write_multi_registers;
    int errors_before;
    logic [31:0] w;
    logic [beat_count-1:0] en;
    logic [addr_width-1:0] addr;
    logic [wr_data_width-1:0] data;
    errors_before = error_count;
    for (int i = 0; i < multi_writes; i++)
    begin
      next_random(w);
      en = w[beat_count-1:0];
      if (en == '0)
        en = '1;
      addr = w[8 +: addr_width];
      if (i % 4 == 0)
        addr = addr_width'(reg_count - 1 - (i / 4) % 3);   // Near the top, forces the wrap to 0
      random_data(data);
      send_write(int'(w[21:20]), en, '1, addr, data);
    end
    read_all();
    report_test("multi-register writes", errors_before);
  endtask

  task automatic contend_for_port;
    int errors_before;
    logic [31:0] w;
    logic [select_width-1:0] requesters;
    logic [beat_count-1:0] c_en [port_count];
    logic [lane_count-1:0] c_mask [port_count];
    logic [addr_width-1:0] c_addr [port_count];
    logic [wr_data_width-1:0] c_data [port_count];
    errors_before = error_count;
    for (int round = 0; round < contention_rounds; round++)
    begin
      next_random(w);
      requesters = w[select_width-1:0];
      if (requesters == '0)
        requesters = '1;
      for (int p = 0; p < port_count; p++)
      begin
        next_random(w);
        c_en[p] = (w[beat_count-1:0] == '0) ? beat_count'(1) : w[beat_count-1:0];
        c_mask[p] = w[8 +: lane_count];
        c_addr[p] = w[16 +: addr_width];
        random_data(c_data[p]);
      end
      for (int p = 0; p < port_count; p++)
      begin
        automatic int q = p;
        if (requesters[q])
          fork
            send_write(q, c_en[q], c_mask[q], c_addr[q], c_data[q]);
          join_none
      end
      wait fork;
    end
    count_check <= 1'b1;
    @(posedge clk);
    count_check <= 1'b0;
    read_all();
    report_test("contention", errors_before);
  endtask

  // The read in the write cycle must return the old contents, the next one the new
  task automatic read_during_write;
    int errors_before;
    logic [31:0] w;
    logic [wr_data_width-1:0] data;
    errors_before = error_count;
    for (int i = 0; i < rdw_writes; i++)
    begin
      next_random(w);
      random_data(data);
      rd_addr <= w[addr_width-1:0];
      rd_req <= 1'b1;
      send_write(i % port_count, beat_count'(1), '1, w[addr_width-1:0], data);
      @(posedge clk);
      rd_req <= 1'b0;
    end
    @(posedge clk);
    report_test("read during write", errors_before);
  endtask

  always @(negedge clk)
  begin : compare_outputs
    logic [select_width-1:0] req;
    logic [select_width-1:0] exp_grant;
    int idx;
    for (int p = 0; p < port_count; p++)
      req[p] = |drv_en[p];
    if (!rst_n)
      model_ptr = 0;
    exp_grant = rr_grant(req, model_ptr);
    for (int k = 0; k < port_count; k++)
      check_value($sformatf("port%0d_wr_grant", k), reg_width'(exp_grant[k]),
                  reg_width'(grant_vec[k]));
    if (rd_pending)
      check_value("rd_data", rd_expect, rd_data);
    else if (!read_seen)
      check_value("rd_data", '0, rd_data);   // Zero from reset until the first read lands
    rd_pending = rd_req;
    if (rd_req)
      rd_expect = shadow[rd_addr];   // Taken before this cycle's write
    if (rst_n)
      read_seen = 1'b1;   // Out of reset the bank samples rd_addr at every edge
    if (count_check)
      check_value("applied_writes", reg_width'(requests_issued), reg_width'(applied_writes));
    if (exp_grant != '0)
    begin
      idx = 0;
      for (int k = 0; k < port_count; k++)
        if (exp_grant[k])
          idx = k;
      apply_write(drv_en[idx], drv_mask[idx], drv_addr[idx], drv_data[idx]);
      applied_writes++;
      model_ptr = (idx + 1) % port_count;
    end
  end

  initial
  begin : main
    rst_n <= 1'b0;
    rd_addr <= '0;
    rd_req <= 1'b0;
    count_check <= 1'b0;
    for (int p = 0; p < port_count; p++)
    begin
      drv_en[p] <= '0;
      drv_mask[p] <= '0;
      drv_addr[p] <= '0;
      drv_data[p] <= '0;
    end
    @(posedge clk);
    check_reset();
    fill_bank();
    write_masked_lanes();
    write_multi_registers();
    contend_for_port();
    read_during_write();
    $display("Checks %0d, mismatches %0d, writes %0d", check_count, error_count, applied_writes);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial
  begin : watchdog
    #(budget_cycles * clk_period + margin_ns);
    $display("Timeout: the run did not finish within %0d cycles", budget_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vgpr_writeback.f ====
source/vgpr_pkg.sv
source/wb_port_pkg.sv
source/wb_port_arbiter.sv
source/wr_port_mux_4to1.sv
source/vgpr_bank.sv
source/vgpr_writeback.sv
bench/vgpr_writeback_tb.sv

// ==== Makefile ====
# Verilator build and run of the vector register write-back testbench

VERILATOR ?= verilator
TOP       ?= vgpr_writeback_tb
FILELIST  ?= vgpr_writeback.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log is searched for the pass line, so a missing line fails the target
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
